// ==== build.sh ====
#!/usr/bin/env bash
# Build and run the fetch stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f sim.f --top-module fetch_tb \
    -Mdir obj_dir -o fetch_sim
if [ $? -ne 0 ]; then
    echo "Verilator compile step failed"
    exit 1
fi

./obj_dir/fetch_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Something failed" "$LOG"; then
    exit 1
fi
exit 0

// ==== sim.f ====
source/fetch_pkg.sv
source/instr_pkg.sv
source/instr_rom.sv
source/fetch_align.sv
source/fetch_credit.sv
source/fetch_unit.sv
source/fetch_top.sv
tb/fetch_tb.sv

// ==== source/fetch_align.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetch_align
    import fetch_pkg::*;
    import instr_pkg::*;
(
    input  wire  [PC_W-1:0]    pc_i,
    input  wire  [WORD_W-1:0]  word_i,
    input  wire  [WORD_W-1:0]  next_i,
    output logic [WADDR_W-1:0] waddr_o,
    output logic [INSTR_W-1:0] instr_o,
    output instr_len_e         len_o
);

    logic              odd_half;
    logic [HALF_W-1:0] first_half;
    logic [HALF_W-1:0] second_half;
    quadrant_e         quadrant;

    ////////////////////////////////////////
    // Word address
    ////////////////////////////////////////

    // Halfword PC drops its lowest bit to address a word
    assign waddr_o  = pc_i[PC_W-1:1];
    assign odd_half = pc_i[0];

    ////////////////////////////////////////
    // Halfword selection
    ////////////////////////////////////////

    // Even PC starts in the low half, odd PC in the high half
    always_comb begin
        if (odd_half) begin
            // When odd, a 32-bit instruction straddles into the next word
            first_half  = word_i[WORD_W-1:HALF_W];
            second_half = next_i[HALF_W-1:0];
        end else begin
            first_half  = word_i[HALF_W-1:0];
            second_half = word_i[WORD_W-1:HALF_W];
        end
    end

    ////////////////////////////////////////
    // Length and assembly
    ////////////////////////////////////////

    assign quadrant = quadrant_e'(first_half[1:0]);

    always_comb begin
        case (quadrant)
            Q0, Q1, Q2: begin
                // Compressed form with the upper half left at zero
                instr_o = {{HALF_W{1'b0}}, first_half};
                len_o   = LEN_16;
            end
            Q_FULL: begin
                instr_o = {second_half, first_half};
                len_o   = LEN_32;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== source/fetch_credit.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetch_credit #(
    parameter int CREDITS = 4
) (
    input  wire  clk_i,
    input  wire  rst_i,
    input  wire  issue_i,
    input  wire  return_i,
    output logic grant_o
);

    localparam int CNT_W = $clog2(CREDITS + 1);

    logic [CNT_W-1:0] count_q;

    ////////////////////////////////////////
    // Credit counter
    ////////////////////////////////////////

    // Starts full, one credit per free slot in the decode queue
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            count_q <= CNT_W'(CREDITS);
        end else begin
            case ({issue_i, return_i})
                2'b10:   count_q <= count_q - CNT_W'(1);
                2'b01:   count_q <= count_q + CNT_W'(1);
                default: count_q <= count_q;  // Idle or both cancel
            endcase
        end
    end

    assign grant_o = (count_q != '0);

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    // Fetch side must honour the grant
    no_issue_when_empty_a : assert property (
        @(posedge clk_i) disable iff (!rst_i)
        issue_i |-> (count_q != '0)
    ) else $error("fetch_credit: issue with no credit left");

    // Decode side cannot free a slot it never received
    no_return_when_full_a : assert property (
        @(posedge clk_i) disable iff (!rst_i)
        return_i |-> (count_q != CNT_W'(CREDITS))
    ) else $error("fetch_credit: credit returned while count is full");

endmodule

`default_nettype wire

// ==== source/fetch_pkg.sv ====
`default_nettype none

package fetch_pkg;

    ////////////////////////////////////////
    // Address widths
    ////////////////////////////////////////

    // Halfword program counter, address bits 31 down to 1
    localparam int PC_W = 31;

    // Word address, address bits 31 down to 2
    localparam int WADDR_W = PC_W - 1;

    // Width of one memory word
    localparam int WORD_W = 32;

    ////////////////////////////////////////
    // Fetch control
    ////////////////////////////////////////

    typedef enum logic {
        ST_IDLE  = 1'b0,
        ST_FETCH = 1'b1
    } fetch_state_e;

    // Restart request, target is a halfword address
    typedef struct packed {
        logic            valid;
        logic [PC_W-1:0] target;
    } redirect_t;

    // Write port into the instruction memory
    typedef struct packed {
        logic               valid;
        logic [WADDR_W-1:0] addr;
        logic [WORD_W-1:0]  data;
    } mem_load_t;

endpackage

`default_nettype wire

// ==== source/fetch_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetch_top
    import fetch_pkg::*;
    import instr_pkg::*;
#(
    parameter int MEM_WORDS = 256,
    parameter int CREDITS   = 4
) (
    input  wire        clk_i,
    input  wire        rst_i,
    input  mem_load_t  load_i,
    input  wire        run_i,
    input  redirect_t  redirect_i,
    output logic       out_valid_o,
    output fetch_out_t out_o,
    input  wire        credit_return_i
);

    logic [PC_W-1:0]    pc;
    logic [WADDR_W-1:0] waddr;
    logic [WORD_W-1:0]  word;
    logic [WORD_W-1:0]  next_word;
    logic [INSTR_W-1:0] instr;
    instr_len_e         len;
    logic               issue;
    logic               grant;

    ////////////////////////////////////////
    // Memory and alignment
    ////////////////////////////////////////

    instr_rom #(
        .MEM_WORDS (MEM_WORDS)
    ) instr_rom_inst (
        .clk_i     (clk_i),
        .load_i    (load_i),
        .rd_addr_i (waddr),
        .rd_word_o (word),
        .rd_next_o (next_word)
    );

    fetch_align fetch_align_inst (
        .pc_i    (pc),
        .word_i  (word),
        .next_i  (next_word),
        .waddr_o (waddr),
        .instr_o (instr),
        .len_o   (len)
    );

    ////////////////////////////////////////
    // Credits and control
    ////////////////////////////////////////

    fetch_credit #(
        .CREDITS (CREDITS)
    ) fetch_credit_inst (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .issue_i  (issue),
        .return_i (credit_return_i),
        .grant_o  (grant)
    );

    fetch_unit fetch_unit_inst (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .run_i       (run_i),
        .redirect_i  (redirect_i),
        .grant_i     (grant),
        .instr_i     (instr),
        .len_i       (len),
        .pc_o        (pc),
        .issue_o     (issue),
        .out_valid_o (out_valid_o),
        .out_o       (out_o)
    );

endmodule

`default_nettype wire

// ==== source/fetch_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetch_unit
    import fetch_pkg::*;
    import instr_pkg::*;
(
    input  wire                clk_i,
    input  wire                rst_i,
    input  wire                run_i,
    input  redirect_t          redirect_i,
    input  wire                grant_i,
    input  wire  [INSTR_W-1:0] instr_i,
    input  instr_len_e         len_i,
    output logic [PC_W-1:0]    pc_o,
    output logic               issue_o,
    output logic               out_valid_o,
    output fetch_out_t         out_o
);

    fetch_state_e    state;
    logic [PC_W-1:0] pc_q;
    logic [PC_W-1:0] pc_step;

    ////////////////////////////////////////
    // Fetch state and issue decision
    ////////////////////////////////////////

    // Follows run_i directly so issue starts in the same cycle
    assign state = run_i ? ST_FETCH : ST_IDLE;

    // A redirect cycle only moves the PC
    assign issue_o = (state == ST_FETCH) && grant_i && !redirect_i.valid;

    assign pc_step = (len_i == LEN_32) ? PC_W'(2) : PC_W'(1);
    assign pc_o    = pc_q;

    ////////////////////////////////////////
    // Program counter
    ////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            pc_q <= '0;
        end else if (redirect_i.valid) begin
            pc_q <= redirect_i.target;
        end else if (issue_o) begin
            pc_q <= pc_q + pc_step;
        end
    end

    ////////////////////////////////////////
    // Output register
    ////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            out_valid_o <= 1'b0;
        end else begin
            out_valid_o <= issue_o;
        end
    end

    // Payload register qualified by out_valid_o
    always_ff @(posedge clk_i) begin
        if (issue_o) begin
            out_o.pc    <= pc_q;
            out_o.instr <= instr_i;
            out_o.len   <= len_i;
        end
    end

    // PC step relies on the length agreeing with the instruction bits
    len_matches_instr_a : assert property (
        @(posedge clk_i) disable iff (!rst_i)
        issue_o |-> ((len_i == LEN_32) == (instr_i[1:0] == 2'b11))
    ) else $error("fetch_unit: instruction length disagrees with its low bits");

endmodule

`default_nettype wire

// ==== source/instr_pkg.sv ====
`default_nettype none

package instr_pkg;

    import fetch_pkg::*;

    ////////////////////////////////////////
    // Instruction encoding
    ////////////////////////////////////////

    // Width of a compressed instruction and of one memory halfword
    localparam int HALF_W = 16;

    // Width of a full instruction
    localparam int INSTR_W = 32;

    // Low two bits of the first halfword
    typedef enum logic [1:0] {
        Q0     = 2'b00,
        Q1     = 2'b01,
        Q2     = 2'b10,
        Q_FULL = 2'b11
    } quadrant_e;

    typedef enum logic {
        LEN_16 = 1'b0,
        LEN_32 = 1'b1
    } instr_len_e;

    ////////////////////////////////////////
    // Fetch output toward decode
    ////////////////////////////////////////

    // Compressed instructions are zero extended in instr
    typedef struct packed {
        logic [PC_W-1:0]    pc;
        logic [INSTR_W-1:0] instr;
        instr_len_e         len;
    } fetch_out_t;

endpackage

`default_nettype wire

// ==== source/instr_rom.sv ====
`timescale 1ns/1ns
`default_nettype none

module instr_rom
    import fetch_pkg::*;
#(
    parameter int MEM_WORDS = 256
) (
    input  wire                clk_i,
    input  mem_load_t          load_i,
    input  wire  [WADDR_W-1:0] rd_addr_i,
    output logic [WORD_W-1:0]  rd_word_o,
    output logic [WORD_W-1:0]  rd_next_o
);

    localparam int IDX_W = $clog2(MEM_WORDS);

    logic [WORD_W-1:0] mem [MEM_WORDS];

    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] next_idx;

    ////////////////////////////////////////
    // Write port
    ////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (load_i.valid) begin
            mem[load_i.addr[IDX_W-1:0]] <= load_i.data;
        end
    end

    ////////////////////////////////////////
    // Read ports
    ////////////////////////////////////////

    // Only the low bits select a word inside the array
    assign rd_idx = rd_addr_i[IDX_W-1:0];

    // Second port wraps at the top of memory
    assign next_idx = (rd_idx == IDX_W'(MEM_WORDS - 1)) ? '0 : rd_idx + IDX_W'(1);

    assign rd_word_o = mem[rd_idx];
    assign rd_next_o = mem[next_idx];

    // A load outside the array would alias onto a lower word
    load_in_range_a : assert property (
        @(posedge clk_i) load_i.valid |-> (load_i.addr < WADDR_W'(MEM_WORDS))
    ) else $error("instr_rom: load address %0d beyond %0d words",
                  load_i.addr, MEM_WORDS);

endmodule

`default_nettype wire

// ==== tb/fetch_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetch_tb
    import fetch_pkg::*;
    import instr_pkg::*;
();

    localparam int MEM_WORDS    = 256;
    localparam int CREDITS      = 4;
    localparam int WAIT_LIMIT   = 400;
    localparam int QUIET_CYCLES = 20;

    typedef enum int {RET_EACH, RET_NONE, RET_RANDOM} ret_mode_e;

    typedef struct {
        string     name;
        int        target;
        bit        redirect;
        int        count;
        ret_mode_e mode;
        int        force_hw;
    } test_t;

    logic       clk;
    logic       rst;
    mem_load_t  load;
    logic       run;
    redirect_t  redirect;
    logic       out_valid;
    fetch_out_t dut_out;
    logic       credit_return;

    logic [31:0]     words [MEM_WORDS];
    logic [31:0]     lcg_state;
    logic [PC_W-1:0] exp_pc;
    int              held;
    int              errors;
    int              tests_run;
    int              tests_failed;
    test_t           tests [$];

    fetch_top #(
        .MEM_WORDS (MEM_WORDS),
        .CREDITS   (CREDITS)
    ) fetch_top_inst (
        .clk_i           (clk),
        .rst_i           (rst),
        .load_i          (load),
        .run_i           (run),
        .redirect_i      (redirect),
        .out_valid_o     (out_valid),
        .out_o           (dut_out),
        .credit_return_i (credit_return)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    ////////////////////////////////////////
    // Helpers and reference model
    ////////////////////////////////////////

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // Halfword p of the program with the word index wrapping like the memory
    function automatic logic [15:0] half_at(input logic [PC_W-1:0] p);
        int widx;
        widx = int'(p >> 1) % MEM_WORDS;
        return p[0] ? words[widx][31:16] : words[widx][15:0];
    endfunction

    function automatic int len_bits(input instr_len_e len);
        return (len == LEN_32) ? 32 : 16;
    endfunction

    task automatic force_full(input int p);
        int widx;
        widx = (p / 2) % MEM_WORDS;
        if (p % 2 == 1) begin
            words[widx][17:16] = 2'b11;
        end else begin
            words[widx][1:0] = 2'b11;
        end
    endtask

    task automatic add_test(input string name, input int target, input bit redirect,
                            input int count, input ret_mode_e mode, input int force_hw);
        test_t t;
        t.name     = name;
        t.target   = target;
        t.redirect = redirect;
        t.count    = count;
        t.mode     = mode;
        t.force_hw = force_hw;
        tests.push_back(t);
    endtask

    // Inputs change 5 ns after the edge when outputs have settled
    task automatic next_cycle();
        @(posedge clk);
        #5;
    endtask

    task automatic check_output(input string name);
        logic [15:0] first;
        logic [31:0] exp_instr;
        instr_len_e  exp_len;
        first = half_at(exp_pc);
        if (first[1:0] == 2'b11) begin
            exp_instr = {half_at(exp_pc + PC_W'(1)), first};
            exp_len   = LEN_32;
        end else begin
            exp_instr = {16'h0000, first};
            exp_len   = LEN_16;
        end
        assert (dut_out.pc == exp_pc) else begin
            $display("[ERROR] %s: pc expected %0d, actual %0d", name, exp_pc, dut_out.pc);
            errors++;
        end
        assert (dut_out.instr == exp_instr) else begin
            $display("[ERROR] %s: instr expected %h, actual %h", name, exp_instr,
                     dut_out.instr);
            errors++;
        end
        assert (dut_out.len == exp_len) else begin
            $display("[ERROR] %s: len expected %0d, actual %0d", name, len_bits(exp_len),
                     len_bits(dut_out.len));
            errors++;
        end
        exp_pc = exp_pc + ((exp_len == LEN_32) ? PC_W'(2) : PC_W'(1));
    endtask

    task automatic expect_quiet(input string name);
        repeat (QUIET_CYCLES) begin
            next_cycle();
            credit_return = 1'b0;
            assert (!out_valid) else begin
                $display("%s: an instruction came out with no credit left", name);
                errors++;
            end
        end
    endtask

    // Collects what is still in flight and hands every credit back
    task automatic drain(input string name);
        int quiet;
        int cycles;
        quiet  = 0;
        cycles = 0;
        while ((held > 0 || quiet < 3) && cycles < WAIT_LIMIT) begin
            next_cycle();
            cycles++;
            credit_return = 1'b0;
            if (out_valid) begin
                check_output(name);
                held++;
                quiet = 0;
            end else begin
                quiet++;
            end
            if (held > 0) begin
                credit_return = 1'b1;
                held--;
            end
        end
        next_cycle();
        credit_return = 1'b0;
        assert (cycles < WAIT_LIMIT) else begin
            $display("%s: timed out while draining outstanding credits", name);
            errors++;
        end
    endtask

    ////////////////////////////////////////
    // One table entry
    ////////////////////////////////////////

    task automatic run_test(input test_t t);
        int          got;
        int          cycles;
        int          start_errors;
        logic [31:0] r;
        start_errors = errors;
        got          = 0;
        cycles       = 0;
        run          = 1'b1;
        if (t.redirect) begin
            exp_pc          = PC_W'(t.target);
            redirect.valid  = 1'b1;
            redirect.target = PC_W'(t.target);
            next_cycle();
            redirect = '0;
            assert (!out_valid) else begin
                $display("%s: output valid right after the redirect cycle", t.name);
                errors++;
            end
        end
        // With a credit back every cycle the stream starts at once and never pauses
        while (got < t.count && cycles < WAIT_LIMIT) begin
            next_cycle();
            cycles++;
            credit_return = 1'b0;
            assert (out_valid || t.mode != RET_EACH) else begin
                $display("%s: no instruction at stream position %0d", t.name, got);
                errors++;
            end
            if (out_valid) begin
                check_output(t.name);
                got++;
                held++;
            end
            r = lcg_next();
            if (held > 0 && (t.mode == RET_EACH || (t.mode == RET_RANDOM && r[20]))) begin
                credit_return = 1'b1;
                held--;
            end
        end
        assert (got == t.count) else begin
            $display("%s: timed out with %0d of %0d instructions", t.name, got, t.count);
            errors++;
        end
        if (t.mode == RET_NONE) begin
            expect_quiet(t.name);
            // One credit back should release exactly one more
            credit_return = 1'b1;
            held--;
            cycles = 0;
            next_cycle();
            credit_return = 1'b0;
            while (!out_valid && cycles < WAIT_LIMIT) begin
                next_cycle();
                cycles++;
            end
            assert (out_valid) else begin
                $display("%s: no instruction after the credit came back", t.name);
                errors++;
            end
            if (out_valid) begin
                check_output(t.name);
                got++;
                held++;
            end
            expect_quiet(t.name);
        end
        run = 1'b0;
        drain(t.name);
        tests_run++;
        if (errors == start_errors) begin
            $display("%-14s PASS  (%0d instructions)", t.name, got);
        end else begin
            tests_failed++;
            $display("%-14s FAIL  (%0d instructions)", t.name, got);
        end
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin
        logic [31:0] r;
        int          idle_errors;
        rst           = 1'b0;
        run           = 1'b0;
        load          = '0;
        redirect      = '0;
        credit_return = 1'b0;
        lcg_state     = 32'd72;
        exp_pc        = '0;
        held          = 0;
        errors        = 0;
        tests_run     = 0;
        tests_failed  = 0;

        add_test("reset_start", 0, 1'b0, 16, RET_EACH, 1);
        add_test("seq_walk", 41, 1'b1, 48, RET_EACH, 41);
        add_test("redirect_even", 200, 1'b1, 12, RET_EACH, 200);
        add_test("redirect_odd", 333, 1'b1, 12, RET_EACH, 333);
        add_test("wrap_top", 511, 1'b1, 8, RET_EACH, 511);
        add_test("credit_limit", 100, 1'b1, CREDITS, RET_NONE, 101);
        add_test("steady_stream", 7, 1'b1, 64, RET_RANDOM, 7);

        // Random program with chosen halfwords turned into 32-bit starts
        for (int i = 0; i < MEM_WORDS; i++) begin
            r = lcg_next();
            words[i][15:0] = r[31:16];
            r = lcg_next();
            words[i][31:16] = r[31:16];
        end
        foreach (tests[i]) begin
            force_full(tests[i].force_hw);
        end

        repeat (3) @(posedge clk);
        #5;
        rst = 1'b1;

        // Load the program while idle with no output expected
        idle_errors = errors;
        for (int i = 0; i < MEM_WORDS; i++) begin
            load.valid = 1'b1;
            load.addr  = WADDR_W'(i);
            load.data  = words[i];
            next_cycle();
            assert (!out_valid) else begin
                $display("reset_idle: output valid while run is low");
                errors++;
            end
        end
        load = '0;
        tests_run++;
        if (errors == idle_errors) begin
            $display("%-14s PASS", "reset_idle");
        end else begin
            tests_failed++;
            $display("%-14s FAIL", "reset_idle");
        end

        foreach (tests[i]) begin
            run_test(tests[i]);
        end

        $display("Tests: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
